//--- verilog/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Virtual address width of the core
`define ADDR_SIZE 40

// One cache line as returned by the instruction cache
`define LINE_BITS 128

// Fetched instruction word
`define INSTR_BITS 32

// Byte offset bits inside a line
`define LINE_OFS_BITS 4

// Page number and page offset split of the virtual address
`define VPN_BITS 28
`define IDX_BITS 12

// Cycles without a response before the request is issued again
`define RETRY_WAIT 16

`endif

//--- verilog/fetch_pkg.sv
`default_nettype none

`include "icache_defs.svh"

package fetch_pkg;

    // Request held by the fetch stage until it is answered
    typedef struct packed {
        logic                  valid;
        logic [`ADDR_SIZE-1:0] vaddr;
        // Drop the buffered line
        logic                  invalidate_buffer;
        // Passed on to the instruction cache
        logic                  invalidate_icache;
    } fetch_req_t;

    // Answer returned to the fetch stage
    typedef struct packed {
        logic                   valid;
        logic [`INSTR_BITS-1:0] data;
        logic                   instr_access_fault;
        logic                   instr_page_fault;
    } fetch_resp_t;

endpackage

`default_nettype wire

//--- verilog/icache_pkg.sv
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    // Request towards the instruction cache and TLB
    typedef struct packed {
        logic                  valid;
        logic                  kill;
        logic [`VPN_BITS-1:0]  vpn;
        logic [`IDX_BITS-1:0]  idx;
    } icache_req_t;

    // Line returned by the instruction cache
    typedef struct packed {
        logic                  valid;
        logic [`ADDR_SIZE-1:0] vaddr;
        logic [`LINE_BITS-1:0] line;
    } icache_resp_t;

    // TLB and page-table walker status for the current request
    typedef struct packed {
        logic miss;
        logic xcpt_if;
        logic ptw_resp_valid;
        logic ptw_invalidate;
    } tlb_status_t;

    // Interface state
    typedef enum logic [1:0] {
        NoReq,
        ReqValid,
        Replay,
        TLBMiss
    } icache_state_t;

endpackage

`default_nettype wire

//--- verilog/icache_req_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_defs.svh"

module icache_req_fsm (
    input  wire logic                     clk_i,
    input  wire logic                     rstn_i,
    input  wire fetch_pkg::fetch_req_t    fetch_req_i,
    input  wire icache_pkg::tlb_status_t  tlb_status_i,
    input  wire logic                     icache_req_ready_i,
    input  wire logic                     resp_match_i,
    input  wire logic                     hit_i,
    input  wire logic                     expired_i,
    output icache_pkg::icache_req_t       icache_req_o,
    output logic                          timer_run_o,
    output logic                          resp_valid_o
);

    icache_pkg::icache_state_t state_q;
    icache_pkg::icache_state_t state_d;
    logic [`ADDR_SIZE-1:0]     last_pc_q;
    logic [`ADDR_SIZE-1:0]     req_addr;
    logic                      line_change;
    logic                      can_answer;
    logic                      do_request;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= icache_pkg::NoReq;
            last_pc_q <= '0;
        end else begin
            state_q   <= state_d;
            last_pc_q <= fetch_req_i.vaddr;
        end
    end

    // Fetch moved to another line since the last cycle
    assign line_change = last_pc_q[`ADDR_SIZE-1:`LINE_OFS_BITS] !=
                         fetch_req_i.vaddr[`ADDR_SIZE-1:`LINE_OFS_BITS];

    // Data is available without a new request
    assign can_answer = hit_i | resp_match_i | tlb_status_i.xcpt_if;

    assign do_request = fetch_req_i.valid & ~hit_i & ~resp_match_i &
                        ~fetch_req_i.invalidate_buffer & icache_req_ready_i &
                        ~tlb_status_i.ptw_resp_valid;

    always_comb begin
        state_d      = state_q;
        resp_valid_o = 1'b0;
        case (state_q)
            icache_pkg::NoReq: begin
                resp_valid_o = fetch_req_i.valid & can_answer & ~tlb_status_i.miss;
                if (do_request) begin
                    state_d = icache_pkg::ReqValid;
                end
            end
            icache_pkg::ReqValid: begin
                if (tlb_status_i.miss) begin
                    state_d = icache_pkg::TLBMiss;
                end else if (fetch_req_i.invalidate_buffer) begin
                    state_d = icache_pkg::NoReq;
                end else if (line_change) begin
                    state_d      = icache_pkg::NoReq;
                    resp_valid_o = fetch_req_i.valid & hit_i;
                end else if (resp_match_i | tlb_status_i.xcpt_if) begin
                    state_d      = icache_pkg::NoReq;
                    resp_valid_o = fetch_req_i.valid;
                end else if (!icache_req_ready_i) begin
                    state_d = icache_pkg::Replay;
                end else if (expired_i) begin
                    // Response considered lost, reissue from NoReq
                    state_d = icache_pkg::NoReq;
                end
            end
            icache_pkg::Replay: begin
                if (tlb_status_i.miss) begin
                    state_d = icache_pkg::TLBMiss;
                end else if (fetch_req_i.invalidate_buffer) begin
                    state_d = icache_pkg::NoReq;
                end else if (line_change) begin
                    state_d      = icache_pkg::NoReq;
                    resp_valid_o = fetch_req_i.valid & hit_i;
                end else if (icache_req_ready_i) begin
                    state_d = icache_pkg::NoReq;
                end
            end
            icache_pkg::TLBMiss: begin
                // Park until the walker answers
                if (tlb_status_i.ptw_resp_valid) begin
                    state_d = icache_pkg::NoReq;
                end
            end
            default: begin
                state_d = icache_pkg::NoReq;
            end
        endcase
    end

    // Only a fresh request in NoReq takes the live PC
    assign req_addr = (state_q == icache_pkg::NoReq) ? fetch_req_i.vaddr : last_pc_q;

    assign icache_req_o = '{
        valid: (state_q == icache_pkg::NoReq) & do_request,
        kill:  tlb_status_i.miss | tlb_status_i.xcpt_if | tlb_status_i.ptw_invalidate,
        vpn:   req_addr[`ADDR_SIZE-1:`IDX_BITS],
        idx:   req_addr[`IDX_BITS-1:0]
    };

    assign timer_run_o = (state_q == icache_pkg::ReqValid);

endmodule

`default_nettype wire

//--- verilog/icache_retry_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_defs.svh"

module icache_retry_timer (
    input  wire logic clk_i,
    input  wire logic rstn_i,
    input  wire logic run_i,
    output logic      expired_o
);

    localparam int unsigned CNT_BITS = $clog2(`RETRY_WAIT);
    localparam logic [CNT_BITS-1:0] LAST_COUNT = CNT_BITS'(`RETRY_WAIT - 1);

    logic [CNT_BITS-1:0] count_q;

    // Counts while waiting, holds at the last value
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            count_q <= '0;
        end else if (!run_i) begin
            count_q <= '0;
        end else if (count_q != LAST_COUNT) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign expired_o = run_i & (count_q == LAST_COUNT);

endmodule

`default_nettype wire

//--- verilog/fetch_line_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_defs.svh"

module fetch_line_buffer (
    input  wire logic                     clk_i,
    input  wire logic                     rstn_i,
    input  wire fetch_pkg::fetch_req_t    fetch_req_i,
    input  wire icache_pkg::icache_resp_t icache_resp_i,
    input  wire icache_pkg::tlb_status_t  tlb_status_i,
    output logic                          hit_o,
    output logic                          resp_match_o,
    output logic [`INSTR_BITS-1:0]        word_o
);

    localparam int unsigned TAG_BITS  = `ADDR_SIZE - `LINE_OFS_BITS;
    localparam int unsigned WORDS     = `LINE_BITS / `INSTR_BITS;
    localparam int unsigned WSEL_BITS = $clog2(WORDS);

    logic [`LINE_BITS-1:0] line_q;
    logic [TAG_BITS-1:0]   tag_q;
    logic                  valid_q;
    logic [TAG_BITS-1:0]   pc_tag;
    logic [`LINE_BITS-1:0] line_sel;
    logic [WSEL_BITS-1:0]  word_idx;
    logic                  write_en;
    logic                  clear;

    assign pc_tag = fetch_req_i.vaddr[`ADDR_SIZE-1:`LINE_OFS_BITS];

    // Response carries the line of the current PC
    assign resp_match_o = icache_resp_i.valid &
                          (icache_resp_i.vaddr[`ADDR_SIZE-1:`LINE_OFS_BITS] == pc_tag);

    // Never buffer a line fetched under a TLB fault or miss
    assign write_en = resp_match_o & ~tlb_status_i.xcpt_if & ~tlb_status_i.miss;

    assign clear = fetch_req_i.invalidate_buffer | tlb_status_i.ptw_invalidate |
                   tlb_status_i.miss;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (clear) begin
            valid_q <= 1'b0;
        end else if (write_en) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_en) begin
            line_q <= icache_resp_i.line;
            tag_q  <= pc_tag;
        end
    end

    assign hit_o = valid_q & (tag_q == pc_tag);

    // Incoming line bypasses the buffer in its arrival cycle
    assign line_sel = resp_match_o ? icache_resp_i.line : line_q;

    assign word_idx = fetch_req_i.vaddr[`LINE_OFS_BITS-1:`LINE_OFS_BITS-WSEL_BITS];

    assign word_o = tlb_status_i.xcpt_if ? '0 :
                    line_sel[word_idx*`INSTR_BITS +: `INSTR_BITS];

endmodule

`default_nettype wire

//--- verilog/icache_interface.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_defs.svh"

module icache_interface (
    input  wire logic                     clk_i,
    input  wire logic                     rstn_i,
    input  wire fetch_pkg::fetch_req_t    fetch_req_i,
    input  wire icache_pkg::icache_resp_t icache_resp_i,
    input  wire logic                     icache_req_ready_i,
    input  wire icache_pkg::tlb_status_t  tlb_status_i,
    output fetch_pkg::fetch_resp_t        fetch_resp_o,
    output icache_pkg::icache_req_t       icache_req_o,
    output logic                          tlb_req_valid_o,
    output logic [`VPN_BITS-1:0]          tlb_req_vpn_o,
    output logic                          icache_invalidate_o
);

    logic                   hit;
    logic                   resp_match;
    logic [`INSTR_BITS-1:0] word;
    logic                   resp_valid;
    logic                   timer_run;
    logic                   expired;

    icache_req_fsm u_req_fsm (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .fetch_req_i        (fetch_req_i),
        .tlb_status_i       (tlb_status_i),
        .icache_req_ready_i (icache_req_ready_i),
        .resp_match_i       (resp_match),
        .hit_i              (hit),
        .expired_i          (expired),
        .icache_req_o       (icache_req_o),
        .timer_run_o        (timer_run),
        .resp_valid_o       (resp_valid)
    );

    icache_retry_timer u_retry_timer (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .run_i     (timer_run),
        .expired_o (expired)
    );

    fetch_line_buffer u_line_buffer (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .fetch_req_i   (fetch_req_i),
        .icache_resp_i (icache_resp_i),
        .tlb_status_i  (tlb_status_i),
        .hit_o         (hit),
        .resp_match_o  (resp_match),
        .word_o        (word)
    );

    // Page faults are not modelled here
    assign fetch_resp_o = '{
        valid:              resp_valid,
        data:               word,
        instr_access_fault: tlb_status_i.xcpt_if,
        instr_page_fault:   1'b0
    };

    // TLB lookup goes out together with the cache request
    assign tlb_req_valid_o = icache_req_o.valid;
    assign tlb_req_vpn_o   = icache_req_o.vpn;

    assign icache_invalidate_o = fetch_req_i.invalidate_icache;

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rstn_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

    // Reset held for the first 10 cycles, released just after an edge
    initial begin
        rstn_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #1;
        rstn_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/icache_interface_sva.sv
`timescale 1ns/100ps
`default_nettype none

module icache_interface_sva (
    input wire logic                    clk_i,
    input wire logic                    rstn_i,
    input wire fetch_pkg::fetch_resp_t  fetch_resp_o,
    input wire icache_pkg::icache_req_t icache_req_o,
    input wire logic                    icache_req_ready_i,
    input wire icache_pkg::tlb_status_t tlb_status_i
);

    // Number of failed properties
    int unsigned fail_count = 0;

    // Requests go out only while the cache can take them
    req_needs_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
        icache_req_o.valid |-> icache_req_ready_i)
    else begin
        $error("icache request raised while the cache was not ready");
        fail_count++;
    end

    no_resp_in_reset: assert property (@(posedge clk_i)
        !rstn_i |-> !fetch_resp_o.valid)
    else begin
        $error("fetch response valid during reset");
        fail_count++;
    end

    // Walker answer and a new request never share a cycle
    no_req_on_ptw_resp: assert property (@(posedge clk_i) disable iff (!rstn_i)
        tlb_status_i.ptw_resp_valid |-> !icache_req_o.valid)
    else begin
        $error("icache request raised in a walker response cycle");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- verification/icache_interface_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_defs.svh"

module icache_interface_tb;

    localparam logic [31:0] LFSR_SEED    = 32'h54d7_436c;
    localparam int unsigned RESP_TIMEOUT = 200;

    logic                     clk;
    logic                     rstn;
    fetch_pkg::fetch_req_t    fetch_req;
    fetch_pkg::fetch_resp_t   fetch_resp;
    icache_pkg::icache_resp_t icache_resp;
    icache_pkg::icache_req_t  icache_req;
    icache_pkg::tlb_status_t  tlb_status;
    logic                     icache_req_ready;
    logic                     tlb_req_valid;
    logic [`VPN_BITS-1:0]     tlb_req_vpn;
    logic                     icache_invalidate;

    // No ready gaps and no dropped responses while set
    logic        quiet = 1'b1;
    int unsigned req_count = 0;

    tb_clock_gen u_clock_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    icache_interface DUT (
        .clk_i               (clk),
        .rstn_i              (rstn),
        .fetch_req_i         (fetch_req),
        .icache_resp_i       (icache_resp),
        .icache_req_ready_i  (icache_req_ready),
        .tlb_status_i        (tlb_status),
        .fetch_resp_o        (fetch_resp),
        .icache_req_o        (icache_req),
        .tlb_req_valid_o     (tlb_req_valid),
        .tlb_req_vpn_o       (tlb_req_vpn),
        .icache_invalidate_o (icache_invalidate)
    );

    bind icache_interface icache_interface_sva u_sva (.*);

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        abort_run();
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw(inout logic [31:0] st, input int unsigned n, output logic [31:0] v);
        v = '0;
        for (int unsigned b = 0; b < n; b++) begin
            st = lfsr_next(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    // Instruction memory content, a function of the word's byte address
    function automatic logic [`INSTR_BITS-1:0] mem_word(input logic [`ADDR_SIZE-1:0] addr);
        return addr[31:0] ^ {4{addr[39:32]}} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [`LINE_BITS-1:0] line_at(input logic [`ADDR_SIZE-1:0] addr);
        logic [`LINE_BITS-1:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*`INSTR_BITS +: `INSTR_BITS] =
                mem_word({addr[`ADDR_SIZE-1:`LINE_OFS_BITS], 2'(w), 2'b00});
        end
        return line;
    endfunction

    function automatic logic [`INSTR_BITS-1:0] golden_instr(input logic [`ADDR_SIZE-1:0] pc,
                                                            input logic xcpt);
        if (xcpt) begin
            return '0;
        end
        return mem_word({pc[`ADDR_SIZE-1:2], 2'b00});
    endfunction

    task automatic check_requests(input int unsigned got, input int unsigned exp);
        assert (got == exp) else value_error("icache_req_o.valid count", got, exp);
    endtask

    task automatic await_response();
        int unsigned n;
        n = 0;
        forever begin
            @(negedge clk);
            if (tlb_status.miss || tlb_status.xcpt_if) begin
                assert (icache_req.kill === 1'b1)
                    else value_error("icache_req_o.kill", icache_req.kill, 1);
            end
            if (fetch_resp.valid) begin
                break;
            end
            n++;
            assert (n < RESP_TIMEOUT) else begin
                $display("No fetch response within %0d cycles for PC 0x%h",
                         RESP_TIMEOUT, fetch_req.vaddr);
                abort_run();
            end
        end
        @(posedge clk);
        #1;
        fetch_req.valid = 1'b0;
        tlb_status      = '0;
    endtask

    task automatic fetch_word(input logic [`ADDR_SIZE-1:0] pc, input logic xcpt);
        fetch_req.valid    = 1'b1;
        fetch_req.vaddr    = pc;
        tlb_status.xcpt_if = xcpt;
        await_response();
    endtask

    // TLB misses for a few cycles, then the walker answers
    task automatic tlb_miss_fetch(input logic [`ADDR_SIZE-1:0] pc, input int unsigned cycles,
                                  output int unsigned refetch_reqs);
        int unsigned base;
        fetch_req.valid = 1'b1;
        fetch_req.vaddr = pc;
        tlb_status.miss = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            assert (fetch_resp.valid === 1'b0)
                else value_error("fetch_resp_o.valid", fetch_resp.valid, 0);
            assert (icache_req.kill === 1'b1)
                else value_error("icache_req_o.kill", icache_req.kill, 1);
            @(posedge clk);
            #1;
        end
        tlb_status.miss           = 1'b0;
        tlb_status.ptw_resp_valid = 1'b1;
        @(posedge clk);
        #1;
        tlb_status.ptw_resp_valid = 1'b0;
        base = req_count;
        await_response();
        refetch_reqs = req_count - base;
    endtask

    // Cache and TLB model, one line in flight at most
    initial begin : cache_model
        logic [31:0]           st;
        logic [31:0]           r;
        logic                  pending;
        int unsigned           countdown;
        logic [`ADDR_SIZE-1:0] resp_addr;
        logic                  next_ready;

        st               = LFSR_SEED;
        pending          = 1'b0;
        countdown        = 0;
        resp_addr        = '0;
        icache_resp      = '0;
        icache_req_ready = 1'b1;
        forever begin
            @(negedge clk);
            // TLB lookup goes out with every cache request
            assert (tlb_req_valid === icache_req.valid)
                else value_error("tlb_req_valid_o", tlb_req_valid, icache_req.valid);
            if (rstn && icache_req.valid) begin
                req_count++;
                assert ({icache_req.vpn, icache_req.idx} === fetch_req.vaddr)
                    else value_error("icache_req_o address", {icache_req.vpn, icache_req.idx},
                                     fetch_req.vaddr);
                assert (tlb_req_vpn === fetch_req.vaddr[`ADDR_SIZE-1:`IDX_BITS])
                    else value_error("tlb_req_vpn_o", tlb_req_vpn,
                                     fetch_req.vaddr[`ADDR_SIZE-1:`IDX_BITS]);
                if (!pending && !icache_req.kill) begin
                    draw(st, 3, r);
                    // Roughly one response in eight is lost
                    if (quiet || r[2:0] != 3'd0) begin
                        pending   = 1'b1;
                        resp_addr = {icache_req.vpn, icache_req.idx};
                        draw(st, 3, r);
                        countdown = 1 + (r % 6);
                    end
                end
            end
            draw(st, 2, r);
            next_ready = quiet || (r[1:0] != 2'd0);
            @(posedge clk);
            #1;
            icache_req_ready  = next_ready;
            icache_resp.valid = 1'b0;
            if (pending) begin
                countdown--;
                if (countdown == 0) begin
                    pending     = 1'b0;
                    icache_resp = '{valid: 1'b1, vaddr: resp_addr, line: line_at(resp_addr)};
                end
            end
        end
    end

    always @(negedge clk) begin
        logic [`INSTR_BITS-1:0] expected;
        if (rstn && fetch_resp.valid) begin
            expected = golden_instr(fetch_req.vaddr, tlb_status.xcpt_if);
            assert (fetch_resp.data === expected)
                else value_error("fetch_resp_o.data", fetch_resp.data, expected);
            assert (fetch_resp.instr_access_fault === tlb_status.xcpt_if)
                else value_error("fetch_resp_o.instr_access_fault",
                                 fetch_resp.instr_access_fault, tlb_status.xcpt_if);
            assert (fetch_resp.instr_page_fault === 1'b0)
                else value_error("fetch_resp_o.instr_page_fault", fetch_resp.instr_page_fault, 0);
        end
    end

    // A failed protocol assertion ends the run at once
    always @(negedge clk) begin
        if (DUT.u_sva.fail_count != 0) begin
            $display("Protocol assertion failed before %0t ns", $time);
            abort_run();
        end
    end

    initial begin : fetch_driver
        logic [31:0]           st;
        logic [31:0]           r;
        logic [31:0]           r2;
        logic [`ADDR_SIZE-1:0] pc;
        int unsigned           base;
        int unsigned           refetch;
        int unsigned           n;

        fetch_req  = '0;
        tlb_status = '0;
        st         = LFSR_SEED;
        n          = 0;

        // Fetch already asks for a PC while reset is held
        fetch_req.valid = 1'b1;
        fetch_req.vaddr = 40'h00_0000_1000;
        repeat (5) @(posedge clk);
        #1;
        fetch_req.valid = 1'b0;

        while (!rstn) begin
            @(posedge clk);
            n++;
            assert (n < 50) else begin
                $display("Reset was not released within 50 cycles");
                abort_run();
            end
        end
        @(posedge clk);
        #1;

        // Whole line word by word, a single request
        base = req_count;
        for (int i = 0; i < 4; i++) begin
            fetch_word(40'h00_0000_1000 + 40'(4 * i), 1'b0);
        end
        check_requests(req_count - base, 1);

        base = req_count;
        fetch_word(40'h12_3456_7890, 1'b0);
        check_requests(req_count - base, 1);

        fetch_req.invalidate_buffer = 1'b1;
        fetch_req.invalidate_icache = 1'b1;
        @(negedge clk);
        assert (icache_invalidate === 1'b1)
            else value_error("icache_invalidate_o", icache_invalidate, 1);
        @(posedge clk);
        #1;
        fetch_req.invalidate_buffer = 1'b0;
        fetch_req.invalidate_icache = 1'b0;
        base = req_count;
        fetch_word(40'h12_3456_7894, 1'b0);
        check_requests(req_count - base, 1);

        // Buffered line is dropped by the miss and fetched again
        tlb_miss_fetch(40'h12_3456_7898, 4, refetch);
        check_requests(refetch, 1);

        fetch_word(40'h00_0abc_0010, 1'b1);

        quiet = 1'b0;
        pc    = 40'h12_3456_7898;
        for (int i = 0; i < 60; i++) begin
            draw(st, 2, r);
            if (r[1:0] == 2'd0) begin
                draw(st, 32, r);
                draw(st, 6, r2);
                pc = {r, r2[5:0], 2'b00};
            end else begin
                pc = pc + 40'd4;
            end
            draw(st, 3, r);
            if (r[2:0] == 3'd0) begin
                fetch_word(pc, 1'b1);
            end else if (r[2:0] == 3'd1) begin
                draw(st, 2, r2);
                tlb_miss_fetch(pc, 1 + r2[1:0], refetch);
            end else begin
                fetch_word(pc, 1'b0);
            end
        end

        if (DUT.u_sva.fail_count != 0) begin
            $display("Protocol assertions failed %0d times", DUT.u_sva.fail_count);
            abort_run();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- icache_interface.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/icache_pkg.sv
verilog/icache_req_fsm.sv
verilog/icache_retry_timer.sv
verilog/fetch_line_buffer.sv
verilog/icache_interface.sv
verification/tb_clock_gen.sv
verification/icache_interface_sva.sv
verification/icache_interface_tb.sv
